//--- src/tcdm_cfg.svh
// --------------------
// build-time sizes of the tcdm subsystem, pulled in by the package and rtl files
// --------------------

`ifndef TCDM_CFG_SVH
`define TCDM_CFG_SVH

`define TCDM_NB_BANKS   4                          // banks, and ports per side
`define TCDM_BANK_WORDS 64                         // words in each bank
`define TCDM_DATA_W     32                         // word width in bits
`define TCDM_ID_W       4                          // transaction id width
`define TCDM_ADDR_W     $clog2(`TCDM_BANK_WORDS)   // word address inside a bank

// axi byte address of the arbiter control register
`define TCDM_CTRL_ADDR  32'h0000_0000

`endif

//--- src/tcdm_pkg.sv
// --------------------
// shared types of the tcdm subsystem
// memory port structs, arbiter control word and axi4-lite channels
// --------------------

`include "tcdm_cfg.svh"

package tcdm_pkg;

  // one memory request, held by the initiator until gnt
  typedef struct packed {
    logic                      req;
    logic                      wen;   // 1 = read, 0 = write
    logic [`TCDM_ADDR_W-1:0]   add;   // word address within the bank
    logic [`TCDM_DATA_W/8-1:0] be;
    logic [`TCDM_DATA_W-1:0]   data;
    logic [`TCDM_ID_W-1:0]     id;
  } tcdm_req_t;

  typedef struct packed {
    logic                    gnt;      // same cycle as req
    logic                    r_valid;  // one cycle after gnt, reads and writes alike
    logic [`TCDM_DATA_W-1:0] r_data;
    logic [`TCDM_ID_W-1:0]   r_id;
  } tcdm_rsp_t;

  // field view of the control word, bit 0 upwards
  typedef struct packed {
    logic [22:0] pad;                 // reads back as zero
    logic [7:0]  low_prio_max_stall;  // 0 disables the starvation guard
    logic        invert_prio;         // 1 makes acc the high side
  } arb_ctrl_t;

  // same 32 bits, raw for the bus and fields for the arbiter
  typedef union packed {
    logic [31:0] raw;
    arb_ctrl_t   f;
  } ctrl_reg_u;

  typedef struct packed {
    logic [31:0] aw_addr;
    logic        aw_valid;
    logic [31:0] w_data;
    logic [3:0]  w_strb;
    logic        w_valid;
    logic        b_ready;
    logic [31:0] ar_addr;
    logic        ar_valid;
    logic        r_ready;
  } axil_req_t;

  typedef struct packed {
    logic        aw_ready;
    logic        w_ready;
    logic [1:0]  b_resp;
    logic        b_valid;
    logic        ar_ready;
    logic [31:0] r_data;
    logic [1:0]  r_resp;
    logic        r_valid;
  } axil_rsp_t;

  localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
  localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

endpackage

//--- src/tcdm_prio_arbiter.sv
// --------------------
// per-bank arbiter between the core and accelerator sides
// unbalanced priority with a stall limit that lets the low side through
// --------------------

`timescale 1ns/1ps

`include "tcdm_cfg.svh"

module tcdm_prio_arbiter #(
  parameter int unsigned NB_CHAN = `TCDM_NB_BANKS
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  tcdm_pkg::arb_ctrl_t ctrl,
  input  tcdm_pkg::tcdm_req_t core_req [NB_CHAN],
  input  tcdm_pkg::tcdm_req_t acc_req  [NB_CHAN],
  output logic [NB_CHAN-1:0]  core_gnt,
  output logic [NB_CHAN-1:0]  acc_gnt,
  output tcdm_pkg::tcdm_req_t bank_req [NB_CHAN],
  input  logic [NB_CHAN-1:0]  bank_gnt,
  output logic [NB_CHAN-1:0]  core_won
);

  logic [NB_CHAN-1:0] core_rq;      // req bits of the core side
  logic [NB_CHAN-1:0] acc_rq;
  logic [NB_CHAN-1:0] hi_rq;        // req bits after the priority swap
  logic [NB_CHAN-1:0] lo_rq;
  logic [NB_CHAN-1:0] hi_pass;      // high side owns this bank
  logic [NB_CHAN-1:0] core_sel;     // bank muxed to core
  logic               force_low;    // stall limit reached
  logic               p_any;        // high side active, after forcing
  logic               l_any;
  logic [7:0]         stall_cnt_q;  // consecutive cycles of conflict

  for (genvar i = 0; i < NB_CHAN; i++)
  begin : g_req_bits
    assign core_rq[i] = core_req[i].req;
    assign acc_rq[i]  = acc_req[i].req;
  end

  assign hi_rq = ctrl.invert_prio ? acc_rq  : core_rq;
  assign lo_rq = ctrl.invert_prio ? core_rq : acc_rq;

  // a zero limit turns the guard off
  assign force_low = (ctrl.low_prio_max_stall != 8'd0) &&
                     (stall_cnt_q >= ctrl.low_prio_max_stall);

  assign p_any = (|hi_rq) & ~force_low;
  assign l_any = |lo_rq;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      stall_cnt_q <= 8'd0;
    end
    else if (p_any && l_any)
    begin
      if (stall_cnt_q != 8'hff)  // hold at top, only matters with limit 0
        stall_cnt_q <= stall_cnt_q + 8'd1;
    end
    else
    begin
      stall_cnt_q <= 8'd0;  // low side got through or nobody competed
    end
  end

  // high side wins a bank only if it asks for that bank and is not held back
  assign hi_pass  = {NB_CHAN{p_any}} & hi_rq;
  assign core_sel = ctrl.invert_prio ? ~hi_pass : hi_pass;
  assign core_won = core_sel;

  for (genvar i = 0; i < NB_CHAN; i++)
  begin : g_bank_mux
    assign bank_req[i] = core_sel[i] ? core_req[i] : acc_req[i];
    assign core_gnt[i] = core_sel[i] & bank_gnt[i];   // loser sees gnt 0
    assign acc_gnt[i]  = ~core_sel[i] & bank_gnt[i];

    // a grant only goes to a side that asks for this bank
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      !(core_gnt[i] && !core_req[i].req) && !(acc_gnt[i] && !acc_req[i].req))
      else $error("grant without request on bank %0d", i);
  end

  // after one cycle at the limit the counter must be back at zero
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ctrl.low_prio_max_stall != 8'd0) && $stable(ctrl.low_prio_max_stall)
      |-> stall_cnt_q <= ctrl.low_prio_max_stall)
    else $error("stall counter above limit");

endmodule

//--- src/tcdm_resp_router.sv
// --------------------
// returns each bank's delayed response to the side that won it
// --------------------

`timescale 1ns/1ps

`include "tcdm_cfg.svh"

module tcdm_resp_router #(
  parameter int unsigned NB_CHAN = `TCDM_NB_BANKS
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  tcdm_pkg::tcdm_req_t     bank_req [NB_CHAN],
  input  logic [NB_CHAN-1:0]      bank_gnt,
  input  logic [NB_CHAN-1:0]      core_won,
  input  logic [`TCDM_DATA_W-1:0] r_data   [NB_CHAN],
  output tcdm_pkg::tcdm_rsp_t     core_rsp [NB_CHAN],
  output tcdm_pkg::tcdm_rsp_t     acc_rsp  [NB_CHAN],
  input  logic [NB_CHAN-1:0]      core_gnt,
  input  logic [NB_CHAN-1:0]      acc_gnt
);

  logic [NB_CHAN-1:0]    vld_q;   // access granted last cycle
  logic [NB_CHAN-1:0]    core_q;  // and core was the winner
  logic [NB_CHAN-1:0]    rd_q;    // it was a read
  logic [`TCDM_ID_W-1:0] id_q [NB_CHAN];

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      vld_q  <= '0;
      core_q <= '0;
    end
    else
    begin
      vld_q  <= bank_gnt;
      core_q <= core_won;
    end
  end

  for (genvar i = 0; i < NB_CHAN; i++)
  begin : g_route
    always_ff @(posedge clk_i)
    begin
      rd_q[i] <= bank_req[i].wen;
      id_q[i] <= bank_req[i].id;
    end

    always_comb
    begin
      core_rsp[i].gnt     = core_gnt[i];
      core_rsp[i].r_valid = vld_q[i] & core_q[i];
      core_rsp[i].r_data  = rd_q[i] ? r_data[i] : '0;  // write acks carry no data
      core_rsp[i].r_id    = id_q[i];
      acc_rsp[i].gnt      = acc_gnt[i];
      acc_rsp[i].r_valid  = vld_q[i] & ~core_q[i];
      acc_rsp[i].r_data   = rd_q[i] ? r_data[i] : '0;
      acc_rsp[i].r_id     = id_q[i];
    end

    // an acc grant answers on the acc side only, one cycle later
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      acc_gnt[i] |=> acc_rsp[i].r_valid && !core_rsp[i].r_valid)
      else $error("acc response lost on bank %0d", i);

    // a core grant answers on the core side only, one cycle later
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      core_gnt[i] |=> core_rsp[i].r_valid && !acc_rsp[i].r_valid)
      else $error("core response lost on bank %0d", i);
  end

endmodule

//--- src/tcdm_bank.sv
// --------------------
// one sram bank, byte-enabled writes, read data one cycle after the grant
// --------------------

`timescale 1ns/1ps

`include "tcdm_cfg.svh"

module tcdm_bank (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  tcdm_pkg::tcdm_req_t     req,
  output logic                    gnt,
  output logic [`TCDM_DATA_W-1:0] r_data
);

  localparam int unsigned WORDS = `TCDM_BANK_WORDS;
  localparam int unsigned NB_BE = `TCDM_DATA_W / 8;

  logic [`TCDM_DATA_W-1:0] mem_q [WORDS];

  // single port, never busy
  assign gnt = req.req;

  always_ff @(posedge clk_i)
  begin
    if (req.req)
    begin
      if (req.wen)
      begin
        r_data <= mem_q[req.add];  // read path
      end
      else
      begin
        for (int b = 0; b < NB_BE; b++)
        begin
          if (req.be[b])
            mem_q[req.add][8*b +: 8] <= req.data[8*b +: 8];
        end
      end
    end
  end

  // depth may be a non power of two
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    req.req |-> (req.add < WORDS))
    else $error("bank address %0d out of range", req.add);

endmodule

//--- src/tcdm_ctrl_axil.sv
// --------------------
// axi4-lite slave with the arbiter control register
// single register, other addresses answer SLVERR
// --------------------

`timescale 1ns/1ps

`include "tcdm_cfg.svh"

module tcdm_ctrl_axil (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  tcdm_pkg::axil_req_t axil_req,
  output tcdm_pkg::axil_rsp_t axil_rsp,
  output tcdm_pkg::arb_ctrl_t ctrl
);

  import tcdm_pkg::*;

  localparam logic [31:0] CTRL_ADDR = `TCDM_CTRL_ADDR;

  ctrl_reg_u   ctrl_q;      // the register itself
  ctrl_reg_u   ctrl_d;
  logic        wr_fire;     // aw and w taken together
  logic        rd_fire;
  logic        wr_hit;
  logic        rd_hit;
  logic        wr_pend_q;   // commit staged write next edge
  logic [31:0] wr_data_q;
  logic [3:0]  wr_strb_q;
  logic        b_valid_q;
  logic [1:0]  b_resp_q;
  logic        r_valid_q;
  logic [1:0]  r_resp_q;
  logic [31:0] r_data_q;

  // word compare, byte offset ignored
  assign wr_hit = (axil_req.aw_addr[31:2] == CTRL_ADDR[31:2]);
  assign rd_hit = (axil_req.ar_addr[31:2] == CTRL_ADDR[31:2]);

  assign wr_fire = axil_req.aw_valid & axil_req.w_valid & ~b_valid_q;
  assign rd_fire = axil_req.ar_valid & ~r_valid_q;

  // staged word merged by strobe, pad forced back to zero
  always_comb
  begin
    ctrl_d = ctrl_q;
    for (int b = 0; b < 4; b++)
    begin
      if (wr_strb_q[b])
        ctrl_d.raw[8*b +: 8] = wr_data_q[8*b +: 8];
    end
    ctrl_d.f.pad = '0;
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      ctrl_q    <= '0;
      wr_pend_q <= 1'b0;
      b_valid_q <= 1'b0;
      b_resp_q  <= AXI_RESP_OKAY;
      r_valid_q <= 1'b0;
      r_resp_q  <= AXI_RESP_OKAY;
    end
    else
    begin
      wr_pend_q <= wr_fire & wr_hit;  // misses are dropped here
      if (wr_pend_q)
        ctrl_q <= ctrl_d;             // arbiter sees it the cycle after bvalid

      if (wr_fire)
      begin
        b_valid_q <= 1'b1;
        b_resp_q  <= wr_hit ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
      end
      else if (axil_req.b_ready)
      begin
        b_valid_q <= 1'b0;
      end

      if (rd_fire)
      begin
        r_valid_q <= 1'b1;
        r_resp_q  <= rd_hit ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
      end
      else if (axil_req.r_ready)
      begin
        r_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (wr_fire)
    begin
      wr_data_q <= axil_req.w_data;
      wr_strb_q <= axil_req.w_strb;
    end
    if (rd_fire)
      r_data_q <= rd_hit ? ctrl_q.raw : 32'd0;
  end

  always_comb
  begin
    axil_rsp.aw_ready = wr_fire;  // both channels accepted in one beat
    axil_rsp.w_ready  = wr_fire;
    axil_rsp.b_valid  = b_valid_q;
    axil_rsp.b_resp   = b_resp_q;
    axil_rsp.ar_ready = ~r_valid_q;
    axil_rsp.r_valid  = r_valid_q;
    axil_rsp.r_resp   = r_resp_q;
    axil_rsp.r_data   = r_data_q;
  end

  assign ctrl = ctrl_q.f;

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    axil_rsp.b_valid && !axil_req.b_ready |=> axil_rsp.b_valid && $stable(axil_rsp.b_resp))
    else $error("bvalid dropped before bready");

endmodule

//--- src/tcdm_subsystem.sv
// --------------------
// tcdm top, banks shared by a core side and an accelerator side
// arbiter settings come over axi4-lite
// --------------------

`timescale 1ns/1ps

`include "tcdm_cfg.svh"

module tcdm_subsystem (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  tcdm_pkg::axil_req_t axil_req,
  output tcdm_pkg::axil_rsp_t axil_rsp,
  input  tcdm_pkg::tcdm_req_t core_req [`TCDM_NB_BANKS],
  output tcdm_pkg::tcdm_rsp_t core_rsp [`TCDM_NB_BANKS],
  input  tcdm_pkg::tcdm_req_t acc_req  [`TCDM_NB_BANKS],
  output tcdm_pkg::tcdm_rsp_t acc_rsp  [`TCDM_NB_BANKS]
);

  import tcdm_pkg::*;

  localparam int unsigned NB = `TCDM_NB_BANKS;

  arb_ctrl_t               ctrl;
  tcdm_req_t               bank_req   [NB];   // winner's request per bank
  logic [NB-1:0]           bank_gnt;
  logic [NB-1:0]           core_gnt;
  logic [NB-1:0]           acc_gnt;
  logic [NB-1:0]           core_won;
  logic [`TCDM_DATA_W-1:0] bank_rdata [NB];

  tcdm_ctrl_axil i_ctrl (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .ctrl     (ctrl)
  );

  tcdm_prio_arbiter #(
    .NB_CHAN (NB)
  ) i_arbiter (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .ctrl     (ctrl),
    .core_req (core_req),
    .acc_req  (acc_req),
    .core_gnt (core_gnt),
    .acc_gnt  (acc_gnt),
    .bank_req (bank_req),
    .bank_gnt (bank_gnt),
    .core_won (core_won)
  );

  // word interleaved, port n goes straight to bank n
  for (genvar i = 0; i < NB; i++)
  begin : g_bank
    tcdm_bank i_bank (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .req    (bank_req[i]),
      .gnt    (bank_gnt[i]),
      .r_data (bank_rdata[i])
    );
  end

  tcdm_resp_router #(
    .NB_CHAN (NB)
  ) i_router (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .bank_req (bank_req),
    .bank_gnt (bank_gnt),
    .core_won (core_won),
    .r_data   (bank_rdata),
    .core_rsp (core_rsp),
    .acc_rsp  (acc_rsp),
    .core_gnt (core_gnt),
    .acc_gnt  (acc_gnt)
  );

endmodule

//--- bench/tb_tcdm_subsystem.sv
// --------------------
// testbench for the tcdm subsystem, replays bench/stim_input.txt against the DUT
// --------------------

`timescale 1ns/1ps

`include "tcdm_cfg.svh"

module tb_tcdm_subsystem;

  import tcdm_pkg::*;

  localparam int NB      = `TCDM_NB_BANKS;
  localparam int WORDS   = `TCDM_BANK_WORDS;
  localparam int TIMEOUT = 40;  // cycles allowed per wait
  localparam logic [31:0] CTRL_ADDR = `TCDM_CTRL_ADDR;

  logic      clk_i;
  logic      rst_ni;
  axil_req_t axil_req;
  axil_rsp_t axil_rsp;
  tcdm_req_t core_req [NB];
  tcdm_rsp_t core_rsp [NB];
  tcdm_req_t acc_req  [NB];
  tcdm_rsp_t acc_rsp  [NB];

  logic [31:0] ref_mem [NB*WORDS];  // reference copy of all banks, bank major
  ctrl_reg_u   model_ctrl;          // what the control register should hold
  integer      seed;

  tcdm_subsystem DUT (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .core_req (core_req),
    .core_rsp (core_rsp),
    .acc_req  (acc_req),
    .acc_rsp  (acc_rsp)
  );

  always #10 clk_i = ~clk_i;  // 20 ns period

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  function automatic tcdm_rsp_t rsp_exp(input logic gnt, input logic vld,
                                        input logic [31:0] id, input logic [31:0] data);
    tcdm_rsp_t r;
    r.gnt     = gnt;
    r.r_valid = vld;
    r.r_id    = id[`TCDM_ID_W-1:0];
    r.r_data  = data;
    return r;
  endfunction

  function automatic tcdm_req_t make_req(input logic wen, input logic [31:0] addr,
                                         input logic [31:0] be, input logic [31:0] data,
                                         input logic [31:0] id);
    tcdm_req_t r;
    r.req  = 1'b1;
    r.wen  = wen;                      // 1 = read
    r.add  = addr[`TCDM_ADDR_W-1:0];
    r.be   = be[`TCDM_DATA_W/8-1:0];
    r.data = data;
    r.id   = id[`TCDM_ID_W-1:0];
    return r;
  endfunction

  function automatic tcdm_rsp_t side_rsp(input logic acc_side, input int bank);
    return acc_side ? acc_rsp[bank] : core_rsp[bank];
  endfunction

  task automatic drive_port(input logic acc_side, input int bank, input tcdm_req_t rq);
    if (acc_side)
      acc_req[bank] = rq;
    else
      core_req[bank] = rq;
  endtask

  task automatic clear_ports();
    for (int i = 0; i < NB; i++)
    begin
      core_req[i] = '0;
      acc_req[i]  = '0;
    end
  endtask

  // byte merge as the bank should do it
  task automatic model_write(input int bank, input logic [31:0] addr,
                             input logic [31:0] be, input logic [31:0] data);
    for (int b = 0; b < 4; b++)
    begin
      if (be[b])
        ref_mem[bank*WORDS + int'(addr)][8*b +: 8] = data[8*b +: 8];
    end
  endtask

  // gnt and r_valid always, id only with r_valid, data only for reads
  task automatic check_rsp(input tcdm_rsp_t got, input tcdm_rsp_t exp,
                           input logic cmp_data, input string what);
    logic bad;
    bad = (got.gnt !== exp.gnt) || (got.r_valid !== exp.r_valid);
    if (exp.r_valid && (got.r_id !== exp.r_id))
      bad = 1'b1;
    if (exp.r_valid && cmp_data && (got.r_data !== exp.r_data))
      bad = 1'b1;
    if (bad)
      stop_run($sformatf("Error at %0t: %s got gnt %b r_valid %b id %h data %h, %s %b %b %h %h",
               $time, what, got.gnt, got.r_valid, got.r_id, got.r_data, "expected",
               exp.gnt, exp.r_valid, exp.r_id, exp.r_data));
  endtask

  task automatic check_ctrl(input ctrl_reg_u got, input ctrl_reg_u exp);
    if (got.raw !== exp.raw)
      stop_run($sformatf("Error at %0t: control read inv %b limit %0d, expected inv %b limit %0d",
               $time, got.f.invert_prio, got.f.low_prio_max_stall,
               exp.f.invert_prio, exp.f.low_prio_max_stall));
  endtask

  task automatic check_axil_resp(input logic [1:0] got, input logic [1:0] exp,
                                 input string what);
    if (got !== exp)
      stop_run($sformatf("Error at %0t: %s is %b, expected %b", $time, what, got, exp));
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp)
      stop_run($sformatf("Error at %0t: %s is %0d, expected %0d", $time, what, got, exp));
  endtask

  function automatic logic axil_flag(input int which);
    case (which)
      0:       return axil_rsp.aw_ready & axil_rsp.w_ready;
      1:       return axil_rsp.b_valid;
      2:       return axil_rsp.ar_ready;
      default: return axil_rsp.r_valid;
    endcase
  endfunction

  task automatic wait_axil(input int which, input string what);
    int n;
    n = 0;
    @(negedge clk_i);
    while (!axil_flag(which))
    begin
      n++;
      if (n > TIMEOUT)
        stop_run($sformatf("timeout waiting for %s", what));
      @(negedge clk_i);
    end
  endtask

  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [31:0] exp_resp);
    @(posedge clk_i);
    #1;
    axil_req.aw_addr  = addr;
    axil_req.aw_valid = 1'b1;
    axil_req.w_data   = data;
    axil_req.w_strb   = 4'hf;
    axil_req.w_valid  = 1'b1;
    wait_axil(0, "awready and wready");
    @(posedge clk_i);
    #1;
    axil_req.aw_valid = 1'b0;
    axil_req.w_valid  = 1'b0;
    axil_req.b_ready  = 1'b1;
    wait_axil(1, "bvalid");
    check_axil_resp(axil_rsp.b_resp, exp_resp[1:0], "write response");
    @(posedge clk_i);
    #1;
    axil_req.b_ready = 1'b0;
    if (addr[31:2] == CTRL_ADDR[31:2])
      model_ctrl.raw = data;  // only the control word is stored
  endtask

  task automatic axil_read(input logic [31:0] addr, input logic [31:0] inv,
                           input logic [31:0] limit, input logic [31:0] exp_resp);
    ctrl_reg_u got;
    ctrl_reg_u exp;
    @(posedge clk_i);
    #1;
    axil_req.ar_addr  = addr;
    axil_req.ar_valid = 1'b1;
    wait_axil(2, "arready");
    @(posedge clk_i);
    #1;
    axil_req.ar_valid = 1'b0;
    axil_req.r_ready  = 1'b1;
    wait_axil(3, "rvalid");
    check_axil_resp(axil_rsp.r_resp, exp_resp[1:0], "read response");
    got.raw = axil_rsp.r_data;
    exp.raw = '0;
    exp.f.invert_prio        = inv[0];
    exp.f.low_prio_max_stall = limit[7:0];
    if (exp_resp[1:0] == AXI_RESP_OKAY)
      check_ctrl(got, exp);
    @(posedge clk_i);
    #1;
    axil_req.r_ready = 1'b0;
  endtask

  task automatic single_access(input logic acc_side, input int bank, input logic wen,
                               input logic [31:0] addr, input logic [31:0] be,
                               input logic [31:0] id, input logic [31:0] data);
    logic [31:0] exp_data;
    int          n;
    tcdm_rsp_t   rsp;
    exp_data = ref_mem[bank*WORDS + int'(addr)];
    @(posedge clk_i);
    #1;
    drive_port(acc_side, bank, make_req(wen, addr, be, data, id));
    n = 0;
    @(negedge clk_i);
    rsp = side_rsp(acc_side, bank);
    while (!rsp.gnt)
    begin
      n++;
      if (n > TIMEOUT)
        stop_run($sformatf("timeout waiting for gnt on bank %0d", bank));
      @(negedge clk_i);
      rsp = side_rsp(acc_side, bank);
    end
    check_rsp(side_rsp(acc_side, bank), rsp_exp(1'b1, 1'b0, 0, 0), 1'b0, "grant cycle");
    check_rsp(side_rsp(!acc_side, bank), rsp_exp(1'b0, 1'b0, 0, 0), 1'b0, "idle side");
    if (!wen)
      model_write(bank, addr, be, data);
    @(posedge clk_i);
    #1;
    clear_ports();
    @(negedge clk_i);  // response exactly one cycle after gnt
    check_rsp(side_rsp(acc_side, bank), rsp_exp(1'b0, 1'b1, id, exp_data), wen, "response");
    check_rsp(side_rsp(!acc_side, bank), rsp_exp(1'b0, 1'b0, 0, 0), 1'b0, "idle side");
  endtask

  // both sides read one bank, high side drops after the run, then the low side
  task automatic conflict_run(input int bank, input int cycles, input int exp_low);
    logic      acc_high;
    logic      hi_gnt;
    logic      lo_gnt;
    logic      hi_prev;
    logic      lo_prev;
    int        limit;
    int        low_cnt;
    int        hi_id;
    int        lo_id;
    tcdm_rsp_t lo_rsp;
    acc_high = model_ctrl.f.invert_prio;
    limit    = int'(model_ctrl.f.low_prio_max_stall);
    hi_id    = acc_high ? 2 : 1;
    lo_id    = acc_high ? 1 : 2;
    hi_prev  = 1'b0;
    lo_prev  = 1'b0;
    low_cnt  = 0;
    @(posedge clk_i);
    #1;
    core_req[bank] = make_req(1'b1, 32'd0, 32'd0, 32'd0, 32'd1);
    acc_req[bank]  = make_req(1'b1, 32'd0, 32'd0, 32'd0, 32'd2);
    for (int k = 1; k <= cycles + 2; k++)
    begin
      lo_gnt = (k == cycles + 1) ||
               ((k <= cycles) && (limit != 0) && ((k % (limit + 1)) == 0));
      hi_gnt = (k <= cycles) && !lo_gnt;
      @(negedge clk_i);
      check_rsp(side_rsp(acc_high, bank), rsp_exp(hi_gnt, hi_prev, hi_id, 0), 1'b0,
                "high side");
      check_rsp(side_rsp(!acc_high, bank), rsp_exp(lo_gnt, lo_prev, lo_id, 0), 1'b0,
                "low side");
      if (k <= cycles)
      begin
        lo_rsp  = side_rsp(!acc_high, bank);
        low_cnt += int'(lo_rsp.gnt);
      end
      hi_prev = hi_gnt;
      lo_prev = lo_gnt;
      @(posedge clk_i);
      #1;
      if (k == cycles)
        drive_port(acc_high, bank, '0);
      if (k == cycles + 1)
        drive_port(!acc_high, bank, '0);
    end
    check_count(low_cnt, exp_low, "low side grants under conflict");
  endtask

  task automatic parallel_access(input int cb, input logic [31:0] cadd, input logic [31:0] cid,
                                 input int ab, input logic [31:0] aadd, input logic [31:0] aid);
    logic [31:0] cdata;
    logic [31:0] adata;
    cdata = $random(seed);
    adata = $random(seed);
    @(posedge clk_i);
    #1;
    core_req[cb] = make_req(1'b0, cadd, 32'hf, cdata, cid);
    acc_req[ab]  = make_req(1'b0, aadd, 32'hf, adata, aid);
    @(negedge clk_i);  // gnt is combinational, same cycle on both banks
    check_rsp(core_rsp[cb], rsp_exp(1'b1, 1'b0, 0, 0), 1'b0, "core parallel grant");
    check_rsp(acc_rsp[ab], rsp_exp(1'b1, 1'b0, 0, 0), 1'b0, "acc parallel grant");
    model_write(cb, cadd, 32'hf, cdata);
    model_write(ab, aadd, 32'hf, adata);
    @(posedge clk_i);
    #1;
    clear_ports();
    @(negedge clk_i);
    check_rsp(core_rsp[cb], rsp_exp(1'b0, 1'b1, cid, 0), 1'b0, "core write ack");
    check_rsp(acc_rsp[ab], rsp_exp(1'b0, 1'b1, aid, 0), 1'b0, "acc write ack");
  endtask

  initial
  begin
    int          fd;
    int          n;
    string       line;
    byte         op;
    logic [31:0] f0, f1, f2, f3, f4, f5, f6, f7;
    clk_i      = 1'b0;
    rst_ni     = 1'b0;
    axil_req   = '0;
    model_ctrl = '0;
    seed       = 95652;
    clear_ports();
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    for (int i = 0; i < NB; i++)
    begin
      check_rsp(core_rsp[i], rsp_exp(1'b0, 1'b0, 0, 0), 1'b0, "core port after reset");
      check_rsp(acc_rsp[i], rsp_exp(1'b0, 1'b0, 0, 0), 1'b0, "acc port after reset");
    end
    if (axil_rsp.b_valid || axil_rsp.r_valid)
      stop_run("axi response valid right after reset");
    fd = $fopen("bench/stim_input.txt", "r");
    if (fd == 0)
      stop_run("cannot open bench/stim_input.txt");
    while (!$feof(fd))
    begin
      line = "";
      n    = $fgets(line, fd);
      if ((n > 0) && (line.len() > 1) && (line.getc(0) != 8'h23))  // skip # lines
      begin
        n = $sscanf(line, "%c %h %h %h %h %h %h %h %h", op, f0, f1, f2, f3, f4, f5, f6, f7);
        case (op)
          "W": axil_write(f0, f1, f2);
          "R": axil_read(f0, f1, f2, f3);
          "S": single_access(f0[0], int'(f1), f2[0], f3, f4, f5, f6[0] ? $random(seed) : f7);
          "C": conflict_run(int'(f0), int'(f1), int'(f2));
          "P": parallel_access(int'(f0), f1, f2, int'(f3), f4, f5);
          default: stop_run($sformatf("unknown operation in stimulus line: %s", line));
        endcase
      end
    end
    $fclose(fd);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

//--- files.f
+incdir+src
src/tcdm_pkg.sv
src/tcdm_prio_arbiter.sv
src/tcdm_resp_router.sv
src/tcdm_bank.sv
src/tcdm_ctrl_axil.sv
src/tcdm_subsystem.sv
bench/tb_tcdm_subsystem.sv

//--- Makefile
# Verilator build and run of the tcdm subsystem testbench

SIM      := verilator
FLAGS    := --binary --assert --timing
TOP      := tb_tcdm_subsystem
FILELIST := files.f
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log

SRCS := $(shell grep -v '^+' $(FILELIST)) src/tcdm_cfg.svh bench/stim_input.txt

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "no result line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- bench/stim_input.txt
# W addr data resp | R addr invert_prio stall_limit resp | C bank cycles low_grants (all hex)
# S side bank wen addr be id rnd data | P cbank caddr cid abank aaddr aid (side 1 = acc, wen 1 = read)
# control register through the union, misses answer slverr
R 00000000 0 00 0
W 00000000 00000007 0
R 00000000 1 03 0
W 00000010 0000000b 2
R 00000000 1 03 0
R 00000008 0 00 2
W 00000000 00000000 0
R 00000000 0 00 0
# full words first, then byte-enabled updates
S 0 0 0 01 f 3 1 0
S 1 1 0 02 f 4 1 0
S 0 2 0 3f f 5 0 cafef00d
S 1 3 0 00 f 6 0 12345678
S 0 1 0 05 f 7 1 0
S 1 0 0 09 f 8 1 0
S 0 0 0 01 3 9 1 0
S 1 3 0 00 c a 0 aabbccdd
S 0 2 0 3f 5 b 1 0
S 1 1 0 02 a c 1 0
S 0 0 1 01 0 d 0 0
S 1 1 1 02 0 e 0 0
S 1 2 1 3f 0 f 0 0
S 0 3 1 00 0 1 0 0
S 0 1 1 05 0 2 0 0
S 1 0 1 09 0 3 0 0
# core high, limit 3, then limit 0
W 00000000 00000006 0
C 1 0c 3
W 00000000 00000000 0
C 2 0a 0
# acc high, limit 2, then limit 0
W 00000000 00000005 0
C 0 09 3
W 00000000 00000001 0
C 3 08 0
# different banks in the same cycle
P 0 10 4 2 11 5
P 3 12 6 1 13 7
W 00000000 00000006 0
P 1 14 8 3 15 9
P 2 16 a 0 17 b
S 0 0 1 10 0 c 0 0
S 1 2 1 11 0 d 0 0
S 1 3 1 12 0 e 0 0
S 0 1 1 13 0 f 0 0
S 1 1 1 14 0 1 0 0
S 0 3 1 15 0 2 0 0
S 0 2 1 16 0 3 0 0
S 1 0 1 17 0 4 0 0
